// File: design/ahb_bus_pkg.sv
/*
  AHB-Lite and APB bus types shared by the bridge and the peripherals
  Word transfers only, so there is no hsize, hburst, hprot or hmastlock
  No pready either, since every APB slave answers in its access cycle
*/
package ahb_bus_pkg;

  // ==================================================
  // Bus widths
  // ==================================================
  localparam int HADDR_W = 32;  // Byte address
  localparam int HDATA_W = 32;  // Data word

  typedef logic [HADDR_W-1:0] haddr_t;
  typedef logic [HDATA_W-1:0] hdata_t;

  // AHB transfer type, encoding as in the AHB spec
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Only OKAY and ERROR exist on AHB-Lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  // ==================================================
  // Request bundles
  // ==================================================
  typedef struct packed {
    haddr_t  haddr;
    htrans_t htrans;
    logic    hwrite;
    hdata_t  hwdata;   // Data phase value, not address phase
  } ahb_req_t;         // 67 bits

  typedef struct packed {
    haddr_t paddr;
    logic   pwrite;
    hdata_t pwdata;
    logic   penable;   // High in the access cycle only
  } apb_req_t;         // 66 bits

endpackage

// File: design/periph_map_pkg.sv
/*
  Address map and register layout of the APB peripherals
  Each peripheral owns a 4 KB region, only the low byte selects a register
  Anything outside the two regions gets the AHB error response
*/
package periph_map_pkg;

  // ==================================================
  // Address map
  // ==================================================
  localparam ahb_bus_pkg::haddr_t GPIO_BASE   = 32'h0000_0000;  // 0x0000 .. 0x0FFF
  localparam ahb_bus_pkg::haddr_t TIMER_BASE  = 32'h0000_1000;  // 0x1000 .. 0x1FFF
  localparam ahb_bus_pkg::haddr_t REGION_MASK = 32'hFFFF_F000;  // 4 KB granule

  localparam int REG_OFF_W = 8;
  typedef logic [REG_OFF_W-1:0] reg_off_t;

  // GPIO registers
  localparam reg_off_t GPIO_OUT      = 8'h00;
  localparam reg_off_t GPIO_OE       = 8'h04;
  localparam reg_off_t GPIO_IN       = 8'h08;  // Read only, synchronized pins
  localparam reg_off_t GPIO_IRQ_STAT = 8'h0C;  // Write 1 to clear
  localparam reg_off_t GPIO_IRQ_MASK = 8'h10;

  // Timer registers
  localparam reg_off_t TMR_LOAD  = 8'h00;
  localparam reg_off_t TMR_CTRL  = 8'h04;  // Bit 0 enable, bit 1 irq enable
  localparam reg_off_t TMR_COUNT = 8'h08;  // Read only
  localparam reg_off_t TMR_STAT  = 8'h0C;  // Bit 0 wrap flag, write 1 to clear

  // ==================================================
  // Peripheral data types
  // ==================================================
  localparam int GPIO_W       = 16;
  localparam int TMR_CNT_W    = 24;
  localparam int TMR_PRESCALE = 8;                     // Clocks per count
  localparam int TMR_PRE_W    = $clog2(TMR_PRESCALE);  // 3 bit prescaler

  typedef logic [GPIO_W-1:0]    gpio_vec_t;
  typedef logic [TMR_CNT_W-1:0] tmr_cnt_t;

endpackage

// File: design/ahb2apb_bridge.sv
/*
  AHB-Lite slave to APB master, one transfer in flight at a time
  Mapped access: 2 wait cycles (APB setup + access), then OKAY
  Unmapped access: two-cycle ERROR response, no psel raised
  hwdata must stay valid until hready returns high
*/
`timescale 1ns/1ps

module ahb2apb_bridge (
  input  logic                  tb_hclk29,
  input  logic                  hresetn29,
  input  ahb_bus_pkg::ahb_req_t i_ahb,
  input  logic                  i_hsel,
  output ahb_bus_pkg::hdata_t   o_hrdata,
  output logic                  o_hready,
  output ahb_bus_pkg::hresp_t   o_hresp,
  output ahb_bus_pkg::apb_req_t o_apb,
  output logic                  o_psel_gpio,
  output logic                  o_psel_tmr,
  input  ahb_bus_pkg::hdata_t   i_prdata_gpio,
  input  ahb_bus_pkg::hdata_t   i_prdata_tmr
);

  typedef enum logic [2:0] {
    IDLE,    // Ready, waiting for an address phase
    SETUP,   // APB setup cycle
    ACCESS,  // APB access cycle, slave samples here
    ERR1,    // ERROR with hready low
    ERR2     // ERROR with hready high
  } state_t;

  state_t              state_q;
  state_t              state_nxt;
  ahb_bus_pkg::haddr_t addr_q;    // Latched address phase
  logic                write_q;
  logic                sel_gpio_q;
  logic                sel_tmr_q;
  ahb_bus_pkg::hdata_t wdata_q;   // hwdata held for the access cycle
  ahb_bus_pkg::hdata_t rdata_q;   // Registered read data
  ahb_bus_pkg::hdata_t prdata_mux;
  logic                trans_vld;
  logic                start;
  logic                hit_gpio;
  logic                hit_tmr;

  // ==================================================
  // Address phase and decode
  // ==================================================
  assign trans_vld = (i_ahb.htrans == ahb_bus_pkg::NONSEQ) ||
                     (i_ahb.htrans == ahb_bus_pkg::SEQ);
  assign start     = i_hsel && trans_vld && o_hready;  // Accepted this edge

  assign hit_gpio = (i_ahb.haddr & periph_map_pkg::REGION_MASK) == periph_map_pkg::GPIO_BASE;
  assign hit_tmr  = (i_ahb.haddr & periph_map_pkg::REGION_MASK) == periph_map_pkg::TIMER_BASE;

  // ==================================================
  // Transfer FSM
  // ==================================================
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_nxt = (hit_gpio || hit_tmr) ? SETUP : ERR1;
        end
      end
      SETUP:  state_nxt = ACCESS;
      ACCESS: state_nxt = IDLE;     // Data returned next cycle with hready high
      ERR1:   state_nxt = ERR2;
      ERR2: begin
        // hready is high here, so a new address phase may land
        if (start) begin
          state_nxt = (hit_gpio || hit_tmr) ? SETUP : ERR1;
        end else begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge tb_hclk29) begin
    if (!hresetn29) begin
      state_q    <= IDLE;
      write_q    <= 1'b0;
      sel_gpio_q <= 1'b0;
      sel_tmr_q  <= 1'b0;
    end else begin
      state_q <= state_nxt;
      if (start) begin
        write_q    <= i_ahb.hwrite;
        sel_gpio_q <= hit_gpio;
        sel_tmr_q  <= hit_tmr;     // Both low on a miss
      end
    end
  end

  // Payload registers
  always_ff @(posedge tb_hclk29) begin
    if (start) addr_q <= i_ahb.haddr;
    if (state_q == SETUP) wdata_q <= i_ahb.hwdata;   // First data phase cycle
    if (state_q == ACCESS) rdata_q <= prdata_mux;
  end

  // Read data by latched select, zero if nothing selected
  assign prdata_mux = sel_gpio_q ? i_prdata_gpio :
                      sel_tmr_q  ? i_prdata_tmr  : '0;

  // ==================================================
  // APB outputs
  // ==================================================
  assign o_apb.paddr   = addr_q;
  assign o_apb.pwrite  = write_q;
  assign o_apb.pwdata  = (state_q == SETUP) ? i_ahb.hwdata : wdata_q;  // Valid from setup on
  assign o_apb.penable = (state_q == ACCESS);

  assign o_psel_gpio = sel_gpio_q && ((state_q == SETUP) || (state_q == ACCESS));
  assign o_psel_tmr  = sel_tmr_q  && ((state_q == SETUP) || (state_q == ACCESS));

  // AHB response
  assign o_hready = (state_q == IDLE) || (state_q == ERR2);
  assign o_hresp  = ((state_q == ERR1) || (state_q == ERR2)) ? ahb_bus_pkg::ERROR
                                                             : ahb_bus_pkg::OKAY;
  assign o_hrdata = rdata_q;

endmodule

// File: design/apb_gpio.sv
/*
  16-pin GPIO on APB, no wait states
  Input pins are asynchronous and pass a 2-flop synchronizer
  Rising edges set sticky status bits, write 1 to clear
  Unused offsets read as zero
*/
`timescale 1ns/1ps

module apb_gpio (
  input  logic                     tb_hclk29,
  input  logic                     hresetn29,
  input  ahb_bus_pkg::apb_req_t    i_apb,
  input  logic                     i_psel,
  output ahb_bus_pkg::hdata_t      o_prdata,
  input  periph_map_pkg::gpio_vec_t i_pins,
  output periph_map_pkg::gpio_vec_t o_pins,
  output periph_map_pkg::gpio_vec_t o_gpio_oe,
  output logic                     o_gpio_irq
);

  periph_map_pkg::reg_off_t  off;
  periph_map_pkg::gpio_vec_t out_q;
  periph_map_pkg::gpio_vec_t oe_q;
  periph_map_pkg::gpio_vec_t mask_q;
  periph_map_pkg::gpio_vec_t stat_q;
  periph_map_pkg::gpio_vec_t sync1_q;    // Metastability stage
  periph_map_pkg::gpio_vec_t sync2_q;    // GPIO_IN value
  periph_map_pkg::gpio_vec_t prev_q;     // Last cycle, for edge detect
  periph_map_pkg::gpio_vec_t rise;
  periph_map_pkg::gpio_vec_t clr;
  logic                      wr;

  assign off = i_apb.paddr[periph_map_pkg::REG_OFF_W-1:0];
  assign wr  = i_psel && i_apb.penable && i_apb.pwrite;  // End of access cycle

  // ==================================================
  // Pin synchronizer and edge detect
  // ==================================================
  assign rise = sync2_q & ~prev_q;

  // Write-1-to-clear, a new edge in the same cycle wins
  assign clr = (wr && off == periph_map_pkg::GPIO_IRQ_STAT) ?
               i_apb.pwdata[periph_map_pkg::GPIO_W-1:0] : '0;

  // ==================================================
  // Registers
  // ==================================================
  always_ff @(posedge tb_hclk29) begin
    if (!hresetn29) begin
      out_q   <= '0;
      oe_q    <= '0;
      mask_q  <= '0;
      stat_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_pins;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      stat_q  <= (stat_q & ~clr) | rise;
      if (wr) begin
        case (off)
          periph_map_pkg::GPIO_OUT:      out_q  <= i_apb.pwdata[periph_map_pkg::GPIO_W-1:0];
          periph_map_pkg::GPIO_OE:       oe_q   <= i_apb.pwdata[periph_map_pkg::GPIO_W-1:0];
          periph_map_pkg::GPIO_IRQ_MASK: mask_q <= i_apb.pwdata[periph_map_pkg::GPIO_W-1:0];
          default: ;  // IN read only, STAT handled above
        endcase
      end
    end
  end

  // Read mux, only while selected
  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (off)
        periph_map_pkg::GPIO_OUT:      o_prdata = {16'h0, out_q};
        periph_map_pkg::GPIO_OE:       o_prdata = {16'h0, oe_q};
        periph_map_pkg::GPIO_IN:       o_prdata = {16'h0, sync2_q};
        periph_map_pkg::GPIO_IRQ_STAT: o_prdata = {16'h0, stat_q};
        periph_map_pkg::GPIO_IRQ_MASK: o_prdata = {16'h0, mask_q};
        default:                       o_prdata = '0;
      endcase
    end
  end

  assign o_pins     = out_q;
  assign o_gpio_oe  = oe_q;
  assign o_gpio_irq = |(stat_q & mask_q);  // Level, held until cleared

endmodule

// File: design/apb_timer.sv
/*
  Down-counting timer on APB, one count every 8 clocks while enabled
  Writing LOAD also reloads the counter and restarts the prescaler
  Counting down from 0 reloads LOAD and sets the sticky STAT flag
*/
`timescale 1ns/1ps

module apb_timer (
  input  logic                  tb_hclk29,
  input  logic                  hresetn29,
  input  ahb_bus_pkg::apb_req_t i_apb,
  input  logic                  i_psel,
  output ahb_bus_pkg::hdata_t   o_prdata,
  output logic                  o_tmr_irq
);

  periph_map_pkg::reg_off_t         off;
  periph_map_pkg::tmr_cnt_t         load_q;
  periph_map_pkg::tmr_cnt_t         count_q;
  logic [1:0]                       ctrl_q;    // [0] enable, [1] irq enable
  logic                             stat_q;
  logic [periph_map_pkg::TMR_PRE_W-1:0] pre_q;
  logic                             tick;      // One count due
  logic                             wr;

  assign off  = i_apb.paddr[periph_map_pkg::REG_OFF_W-1:0];
  assign wr   = i_psel && i_apb.penable && i_apb.pwrite;
  assign tick = ctrl_q[0] &&
                (pre_q == periph_map_pkg::TMR_PRE_W'(periph_map_pkg::TMR_PRESCALE - 1));

  // ==================================================
  // Prescaler, counter and status
  // ==================================================
  always_ff @(posedge tb_hclk29) begin
    if (!hresetn29) begin
      load_q  <= '0;
      count_q <= '0;
      ctrl_q  <= '0;
      stat_q  <= 1'b0;
      pre_q   <= '0;
    end else begin
      // Prescaler runs only while enabled
      pre_q <= ctrl_q[0] ? pre_q + 1'b1 : '0;

      if (wr && off == periph_map_pkg::TMR_STAT && i_apb.pwdata[0]) stat_q <= 1'b0;
      if (wr && off == periph_map_pkg::TMR_CTRL) ctrl_q <= i_apb.pwdata[1:0];

      if (wr && off == periph_map_pkg::TMR_LOAD) begin
        load_q  <= i_apb.pwdata[periph_map_pkg::TMR_CNT_W-1:0];
        count_q <= i_apb.pwdata[periph_map_pkg::TMR_CNT_W-1:0];
        pre_q   <= '0;
      end else if (tick) begin
        if (count_q == '0) begin
          count_q <= load_q;   // Wrap
          stat_q  <= 1'b1;     // Set beats a same-cycle clear
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  // Read mux
  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (off)
        periph_map_pkg::TMR_LOAD:  o_prdata = {8'h0, load_q};
        periph_map_pkg::TMR_CTRL:  o_prdata = {30'h0, ctrl_q};
        periph_map_pkg::TMR_COUNT: o_prdata = {8'h0, count_q};
        periph_map_pkg::TMR_STAT:  o_prdata = {31'h0, stat_q};
        default:                   o_prdata = '0;
      endcase
    end
  end

  assign o_tmr_irq = stat_q && ctrl_q[1];

endmodule

// File: design/apb_subsystem.sv
/*
  AHB-Lite to APB subsystem top, bridge plus GPIO and timer
  Single clock and synchronous active-low reset for the whole block
  Map: GPIO at 0x0000_0000, timer at 0x0000_1000, 4 KB each
*/
`timescale 1ns/1ps

module apb_subsystem (
  input  logic                      tb_hclk29,
  input  logic                      hresetn29,
  input  ahb_bus_pkg::ahb_req_t     i_ahb,
  input  logic                      i_hsel,
  output ahb_bus_pkg::hdata_t       o_hrdata,
  output logic                      o_hready,
  output ahb_bus_pkg::hresp_t       o_hresp,
  input  periph_map_pkg::gpio_vec_t i_gpio_in,
  output periph_map_pkg::gpio_vec_t o_gpio_out,
  output periph_map_pkg::gpio_vec_t o_gpio_oe,
  output logic                      o_gpio_irq,
  output logic                      o_tmr_irq
);

  // ==================================================
  // APB side wiring
  // ==================================================
  ahb_bus_pkg::apb_req_t apb_req;       // Shared by both slaves
  logic                  psel_gpio;
  logic                  psel_tmr;
  ahb_bus_pkg::hdata_t   prdata_gpio;
  ahb_bus_pkg::hdata_t   prdata_tmr;

  ahb2apb_bridge u_bridge (
    .tb_hclk29     (tb_hclk29),
    .hresetn29     (hresetn29),
    .i_ahb         (i_ahb),
    .i_hsel        (i_hsel),
    .o_hrdata      (o_hrdata),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp),
    .o_apb         (apb_req),
    .o_psel_gpio   (psel_gpio),
    .o_psel_tmr    (psel_tmr),
    .i_prdata_gpio (prdata_gpio),
    .i_prdata_tmr  (prdata_tmr)
  );

  apb_gpio u_gpio (
    .tb_hclk29  (tb_hclk29),
    .hresetn29  (hresetn29),
    .i_apb      (apb_req),
    .i_psel     (psel_gpio),
    .o_prdata   (prdata_gpio),
    .i_pins     (i_gpio_in),    // Asynchronous pins
    .o_pins     (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe),
    .o_gpio_irq (o_gpio_irq)
  );

  apb_timer u_timer (
    .tb_hclk29 (tb_hclk29),
    .hresetn29 (hresetn29),
    .i_apb     (apb_req),
    .i_psel    (psel_tmr),
    .o_prdata  (prdata_tmr),
    .o_tmr_irq (o_tmr_irq)
  );

endmodule

// File: dv/tb_clk_gen.sv
/*
  Clock and reset source for the subsystem testbench
  10 ns clock period, reset low for the first 3 rising edges
  Reset is released with a non-blocking update on the edge
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic tb_hclk29,
  output logic hresetn29
);

  initial tb_hclk29 = 1'b0;
  always #5 tb_hclk29 = ~tb_hclk29;  // 100 MHz

  initial begin
    hresetn29 = 1'b0;
    repeat (3) @(posedge tb_hclk29);
    hresetn29 <= 1'b1;               // Seen high from the 4th edge on
  end

endmodule

// File: dv/apb_subsystem_tb.sv
/*
  Testbench for the AHB-Lite to APB subsystem
  One AHB transfer at a time, inputs change on the rising edge
  Outputs are sampled on the falling edge, where they are stable
  Expected values follow the register map and the bus timing rules
*/
`timescale 1ns/1ps

module apb_subsystem_tb;

  localparam int HREADY_TIMEOUT = 20;                                // Cycles per transfer
  localparam int IRQ_TIMEOUT    = 16 * periph_map_pkg::TMR_PRESCALE;  // Well past one wrap
  localparam int NUM_ENTRIES    = 11;
  localparam ahb_bus_pkg::haddr_t UNMAPPED = 32'h0000_2000;           // Past the timer region

  typedef struct packed {
    ahb_bus_pkg::haddr_t addr;
    logic                write;
    ahb_bus_pkg::hdata_t wdata;
    ahb_bus_pkg::hdata_t exp_data;    // Reads only
    ahb_bus_pkg::hresp_t exp_resp;
  } entry_t;

  logic                      tb_hclk29;
  logic                      hresetn29;
  ahb_bus_pkg::ahb_req_t     ahb_req;
  logic                      hsel;
  ahb_bus_pkg::hdata_t       hrdata;
  logic                      hready;
  ahb_bus_pkg::hresp_t       hresp;
  periph_map_pkg::gpio_vec_t gpio_in;
  periph_map_pkg::gpio_vec_t gpio_out;
  periph_map_pkg::gpio_vec_t gpio_oe;
  logic                      gpio_irq;
  logic                      tmr_irq;

  entry_t stim_tbl [NUM_ENTRIES];
  integer seed;
  int     err_count;
  int     test_count;
  int     fail_count;

  tb_clk_gen u_clk_gen (
    .tb_hclk29 (tb_hclk29),
    .hresetn29 (hresetn29)
  );

  apb_subsystem apb_subsystem_i (
    .tb_hclk29  (tb_hclk29),
    .hresetn29  (hresetn29),
    .i_ahb      (ahb_req),
    .i_hsel     (hsel),
    .o_hrdata   (hrdata),
    .o_hready   (hready),
    .o_hresp    (hresp),
    .i_gpio_in  (gpio_in),
    .o_gpio_out (gpio_out),
    .o_gpio_oe  (gpio_oe),
    .o_gpio_irq (gpio_irq),
    .o_tmr_irq  (tmr_irq)
  );

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_data(input string name, input ahb_bus_pkg::hdata_t exp_v,
                            input ahb_bus_pkg::hdata_t got_v);
    if (got_v !== exp_v) begin
      $display("** Error %s exp %h got %h", name, exp_v, got_v);
      err_count++;
    end
  endtask

  task automatic check_resp(input string name, input ahb_bus_pkg::hresp_t exp_v,
                            input ahb_bus_pkg::hresp_t got_v);
    if (got_v !== exp_v) begin
      $display("** Error %s exp %h got %h", name, exp_v, got_v);
      err_count++;
    end
  endtask

  task automatic check_gpio(input string name, input periph_map_pkg::gpio_vec_t exp_v,
                            input periph_map_pkg::gpio_vec_t got_v);
    if (got_v !== exp_v) begin
      $display("** Error %s exp %h got %h", name, exp_v, got_v);
      err_count++;
    end
  endtask

  function automatic ahb_bus_pkg::haddr_t gpio_addr(input periph_map_pkg::reg_off_t off);
    return periph_map_pkg::GPIO_BASE | {24'h0, off};
  endfunction

  function automatic ahb_bus_pkg::haddr_t tmr_addr(input periph_map_pkg::reg_off_t off);
    return periph_map_pkg::TIMER_BASE | {24'h0, off};
  endfunction

  // ==================================================
  // AHB transfer and its timing checks
  // ==================================================
  task automatic ahb_transfer(input ahb_bus_pkg::haddr_t addr, input logic write,
                              input ahb_bus_pkg::hdata_t wdata,
                              output ahb_bus_pkg::hdata_t rdata,
                              output ahb_bus_pkg::hresp_t resp,
                              output ahb_bus_pkg::hresp_t first_resp, output int waits);
    @(posedge tb_hclk29);
    ahb_req.haddr  <= addr;
    ahb_req.htrans <= ahb_bus_pkg::NONSEQ;
    ahb_req.hwrite <= write;
    hsel           <= 1'b1;
    @(posedge tb_hclk29);                  // Address phase
    ahb_req.htrans <= ahb_bus_pkg::IDLE;
    ahb_req.hwdata <= wdata;               // Held through the data phase
    hsel           <= 1'b0;
    waits = 0;
    @(negedge tb_hclk29);
    first_resp = hresp;                    // First data phase cycle
    while (!hready && waits < HREADY_TIMEOUT) begin
      waits++;
      @(negedge tb_hclk29);
    end
    if (!hready) begin
      $display("Timeout: o_hready stayed low for %0d cycles at address %h",
               HREADY_TIMEOUT, addr);
      err_count++;
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  // OKAY waits 2 cycles, ERROR holds hready low for 1
  task automatic check_timing(input ahb_bus_pkg::hresp_t exp_resp,
                              input ahb_bus_pkg::hresp_t first_resp,
                              input ahb_bus_pkg::hresp_t resp, input int waits);
    int exp_waits;
    exp_waits = (exp_resp == ahb_bus_pkg::OKAY) ? 2 : 1;
    if (waits != exp_waits) begin
      $display("o_hready was low for %0d cycles instead of %0d", waits, exp_waits);
      err_count++;
    end
    check_resp("o_hresp first cycle", exp_resp, first_resp);
    check_resp("o_hresp", exp_resp, resp);
  endtask

  task automatic run_entry(input entry_t e);
    ahb_bus_pkg::hdata_t rdata;
    ahb_bus_pkg::hresp_t resp;
    ahb_bus_pkg::hresp_t first_resp;
    int                  waits;
    ahb_transfer(e.addr, e.write, e.wdata, rdata, resp, first_resp, waits);
    check_timing(e.exp_resp, first_resp, resp, waits);
    if (!e.write && e.exp_resp == ahb_bus_pkg::OKAY) check_data("o_hrdata", e.exp_data, rdata);
  endtask

  task automatic reg_write(input ahb_bus_pkg::haddr_t addr, input ahb_bus_pkg::hdata_t data);
    run_entry('{addr, 1'b1, data, '0, ahb_bus_pkg::OKAY});
  endtask

  task automatic reg_read(input ahb_bus_pkg::haddr_t addr, input ahb_bus_pkg::hdata_t exp_v);
    run_entry('{addr, 1'b0, '0, exp_v, ahb_bus_pkg::OKAY});
  endtask

  // Read with timing checks only, value judged by the caller
  task automatic read_value(input ahb_bus_pkg::haddr_t addr, output ahb_bus_pkg::hdata_t data);
    ahb_bus_pkg::hresp_t resp;
    ahb_bus_pkg::hresp_t first_resp;
    int                  waits;
    ahb_transfer(addr, 1'b0, '0, data, resp, first_resp, waits);
    check_timing(ahb_bus_pkg::OKAY, first_resp, resp, waits);
  endtask

  task automatic wait_irq(input bit use_tmr, input int limit, output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge tb_hclk29);
      seen = use_tmr ? tmr_irq : gpio_irq;
      cycles++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("[pass] %s", name);
    end else begin
      fail_count++;
      $display("[FAIL] %s, %0d errors", name, err_count - errs_before);
    end
  endtask

  // Register write/readback, then the unmapped region
  task automatic fill_table();
    ahb_bus_pkg::hdata_t out_v;
    ahb_bus_pkg::hdata_t oe_v;
    ahb_bus_pkg::hdata_t mask_v;
    ahb_bus_pkg::hdata_t load_v;
    ahb_bus_pkg::haddr_t a_out;
    ahb_bus_pkg::haddr_t a_oe;
    ahb_bus_pkg::haddr_t a_mask;
    ahb_bus_pkg::haddr_t a_load;
    out_v  = $random(seed) & 32'h0000_FFFF;   // 16 pins
    oe_v   = $random(seed) & 32'h0000_FFFF;
    mask_v = $random(seed) & 32'h0000_FFFF;
    load_v = $random(seed) & 32'h00FF_FFFF;   // 24 bit counter
    a_out  = gpio_addr(periph_map_pkg::GPIO_OUT);
    a_oe   = gpio_addr(periph_map_pkg::GPIO_OE);
    a_mask = gpio_addr(periph_map_pkg::GPIO_IRQ_MASK);
    a_load = tmr_addr(periph_map_pkg::TMR_LOAD);
    stim_tbl[0]  = '{a_out, 1'b1, out_v, '0, ahb_bus_pkg::OKAY};
    stim_tbl[1]  = '{a_out, 1'b0, '0, out_v, ahb_bus_pkg::OKAY};
    stim_tbl[2]  = '{a_oe, 1'b1, oe_v, '0, ahb_bus_pkg::OKAY};
    stim_tbl[3]  = '{a_oe, 1'b0, '0, oe_v, ahb_bus_pkg::OKAY};
    stim_tbl[4]  = '{a_mask, 1'b1, mask_v, '0, ahb_bus_pkg::OKAY};
    stim_tbl[5]  = '{a_mask, 1'b0, '0, mask_v, ahb_bus_pkg::OKAY};
    stim_tbl[6]  = '{a_load, 1'b1, load_v, '0, ahb_bus_pkg::OKAY};
    stim_tbl[7]  = '{a_load, 1'b0, '0, load_v, ahb_bus_pkg::OKAY};
    stim_tbl[8]  = '{UNMAPPED, 1'b0, '0, '0, ahb_bus_pkg::ERROR};
    // Inverted pins, so a write leaking into GPIO_OUT shows up
    stim_tbl[9]  = '{UNMAPPED, 1'b1, out_v ^ 32'h0000_FFFF, '0, ahb_bus_pkg::ERROR};
    stim_tbl[10] = '{a_out, 1'b0, '0, out_v, ahb_bus_pkg::OKAY};   // Recovery after ERROR
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    ahb_bus_pkg::hdata_t       rnd;
    ahb_bus_pkg::hdata_t       cnt;
    periph_map_pkg::gpio_vec_t pins_v;
    int                        errs;
    int                        cycles;
    bit                        seen;

    seed       = 32'hf826_1975;
    ahb_req    = '0;
    hsel       = 1'b0;
    gpio_in    = '0;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;

    // Reset state
    errs   = err_count;
    cycles = 0;
    while (hresetn29 !== 1'b1 && cycles < HREADY_TIMEOUT) begin
      @(posedge tb_hclk29);
      cycles++;
    end
    if (hresetn29 !== 1'b1) begin
      $display("Reset was never released");
      err_count++;
    end
    @(negedge tb_hclk29);
    if (hready !== 1'b1) begin
      $display("o_hready is not high after reset");
      err_count++;
    end
    check_resp("o_hresp", ahb_bus_pkg::OKAY, hresp);
    if (gpio_irq !== 1'b0 || tmr_irq !== 1'b0) begin
      $display("An interrupt is high after reset");
      err_count++;
    end
    check_gpio("o_gpio_oe", '0, gpio_oe);
    report_test("reset state", errs);

    // Table of register accesses
    fill_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      errs = err_count;
      run_entry(stim_tbl[i]);
      report_test($sformatf("entry %0d %s %h", i, stim_tbl[i].write ? "write" : "read",
                            stim_tbl[i].addr), errs);
    end
    errs = err_count;
    check_gpio("o_gpio_out", stim_tbl[0].wdata[15:0], gpio_out);
    check_gpio("o_gpio_oe", stim_tbl[2].wdata[15:0], gpio_oe);
    report_test("gpio output pins", errs);

    // Pin input through the synchronizer
    errs   = err_count;
    rnd    = $random(seed);
    pins_v = rnd[15:0] | 16'h0001;        // At least one rising edge
    @(posedge tb_hclk29);
    gpio_in <= pins_v;
    reg_read(gpio_addr(periph_map_pkg::GPIO_IN), {16'h0, pins_v});
    report_test("gpio input", errs);

    // Edges from all-zero set status equal to the pin value
    errs = err_count;
    reg_write(gpio_addr(periph_map_pkg::GPIO_IRQ_MASK), 32'h0);
    if (gpio_irq !== 1'b0) begin
      $display("o_gpio_irq high with every mask bit clear");
      err_count++;
    end
    reg_write(gpio_addr(periph_map_pkg::GPIO_IRQ_MASK), {16'h0, pins_v});
    wait_irq(1'b0, HREADY_TIMEOUT, seen);
    if (!seen) begin
      $display("o_gpio_irq did not rise with the mask set");
      err_count++;
    end
    reg_read(gpio_addr(periph_map_pkg::GPIO_IRQ_STAT), {16'h0, pins_v});
    reg_write(gpio_addr(periph_map_pkg::GPIO_IRQ_STAT), 32'h0000_FFFF);
    if (gpio_irq !== 1'b0) begin
      $display("o_gpio_irq still high after clearing the status");
      err_count++;
    end
    report_test("gpio interrupt", errs);

    // Timer, load 4 then enable count and irq
    errs = err_count;
    reg_write(tmr_addr(periph_map_pkg::TMR_LOAD), 32'd4);
    reg_write(tmr_addr(periph_map_pkg::TMR_CTRL), 32'h3);
    repeat (2) begin
      read_value(tmr_addr(periph_map_pkg::TMR_COUNT), cnt);
      if (cnt > 32'd4) begin
        $display("TMR_COUNT read %h, above the load value 4", cnt);
        err_count++;
      end
    end
    wait_irq(1'b1, IRQ_TIMEOUT, seen);
    if (!seen) begin
      $display("o_tmr_irq did not rise within %0d cycles", IRQ_TIMEOUT);
      err_count++;
    end
    reg_write(tmr_addr(periph_map_pkg::TMR_STAT), 32'h1);
    wait_irq(1'b1, 2 * periph_map_pkg::TMR_PRESCALE, seen);   // Next wrap is 5 counts away
    if (seen) begin
      $display("o_tmr_irq set again before the next wrap");
      err_count++;
    end
    wait_irq(1'b1, IRQ_TIMEOUT, seen);
    if (!seen) begin
      $display("o_tmr_irq did not rise again at the next wrap");
      err_count++;
    end
    report_test("timer", errs);

    $display("Tests: %0d run, %0d failed, %0d check errors", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: build.f
design/ahb_bus_pkg.sv
design/periph_map_pkg.sv
design/ahb2apb_bridge.sv
design/apb_gpio.sv
design/apb_timer.sv
design/apb_subsystem.sv
dv/tb_clk_gen.sv
dv/apb_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# Builds the subsystem testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module apb_subsystem_tb -f build.f -o sim \
  && ./obj_dir/sim | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -q "^Regression passed$" sim.log && exit 0 || exit 1
